// File: rhythm_game_pkg.sv
package rhythm_game_pkg;

    // Game dimensions
    localparam int N_CHARTS    = 4;
    localparam int CHART_LEN   = 16;
    localparam int STEP_CYCLES = 16;
    localparam int N_NOTES     = 7;

    // One bit per note key
    typedef logic [N_NOTES-1:0] note_mask_t;

    typedef logic [$clog2(N_CHARTS)-1:0]  chart_id_t;
    typedef logic [$clog2(CHART_LEN)-1:0] step_idx_t;

    // Chart memory address, chart number above slot number
    typedef logic [$bits(chart_id_t)+$bits(step_idx_t)-1:0] chart_addr_t;

    // Hit or miss count, at most N_NOTES * CHART_LEN
    typedef logic [7:0] score_t;

    typedef enum logic {
        PAGE_MENU,
        PAGE_PLAY
    } page_t;

    // One-cycle press pulses
    typedef struct packed {
        note_mask_t note_press;
        logic       up;
        logic       down;
        logic       enter;
        logic       back;
        logic       rec;
    } user_in_t;

    typedef struct packed {
        chart_id_t chart_id;
        logic      rec_mode;
        score_t    score;
        score_t    misses;
    } play_result_t;

    typedef struct packed {
        page_t     page;
        chart_id_t chart_id;
        logic      rec_mode;
        step_idx_t step_idx;
        score_t    score;
        score_t    best_score;
    } game_status_t;

endpackage

// File: key_input_unit.sv
`timescale 1ns/1ps

module key_input_unit (
    input  logic                        clk,
    input  logic                        sys_rst,
    input  rhythm_game_pkg::note_mask_t note_keys,
    input  logic                        btn_up,
    input  logic                        btn_down,
    input  logic                        btn_enter,
    input  logic                        btn_back,
    input  logic                        btn_rec,
    output rhythm_game_pkg::user_in_t   user_in
);

    // Raw keys laid out in the same order as the user input struct
    logic [$bits(rhythm_game_pkg::user_in_t)-1:0] raw_keys;
    logic [$bits(rhythm_game_pkg::user_in_t)-1:0] sync_a;
    logic [$bits(rhythm_game_pkg::user_in_t)-1:0] sync_b;
    logic [$bits(rhythm_game_pkg::user_in_t)-1:0] prev_keys;

    assign raw_keys = {note_keys, btn_up, btn_down, btn_enter, btn_back, btn_rec};

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            sync_a    <= '0;
            sync_b    <= '0;
            prev_keys <= '0;
            user_in   <= '0;
        end else begin
            sync_a    <= raw_keys;
            sync_b    <= sync_a;
            prev_keys <= sync_b;
            // Rising edge of the synchronized key, one pulse per press
            user_in   <= rhythm_game_pkg::user_in_t'(sync_b & ~prev_keys);
        end
    end

endmodule

// File: chart_store.sv
`timescale 1ns/1ps

module chart_store (
    input  logic                         clk,
    input  logic                         sys_rst,
    input  rhythm_game_pkg::chart_addr_t rd_addr,
    input  logic                         wr_en,
    input  rhythm_game_pkg::chart_addr_t wr_addr,
    input  rhythm_game_pkg::note_mask_t  wr_data,
    output rhythm_game_pkg::note_mask_t  rd_data
);

    // All charts back to back, one note mask per slot
    rhythm_game_pkg::note_mask_t mem [rhythm_game_pkg::N_CHARTS * rhythm_game_pkg::CHART_LEN];

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            // Charts start empty until recorded
            for (int i = 0; i < rhythm_game_pkg::N_CHARTS * rhythm_game_pkg::CHART_LEN; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr_en) begin
                mem[wr_addr] <= wr_data;
            end
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: record_store.sv
`timescale 1ns/1ps

module record_store (
    input  logic                          clk,
    input  logic                          sys_rst,
    input  rhythm_game_pkg::play_result_t result,
    input  logic                          result_valid,
    input  logic                          result_ready,
    input  rhythm_game_pkg::chart_id_t    rd_id,
    output rhythm_game_pkg::score_t       best_score
);

    rhythm_game_pkg::score_t best [rhythm_game_pkg::N_CHARTS];
    logic new_best;

    // Only accepted play runs that beat the stored score count
    assign new_best = result_valid && result_ready && !result.rec_mode &&
                      (result.score > best[result.chart_id]);

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            for (int i = 0; i < rhythm_game_pkg::N_CHARTS; i++) begin
                best[i] <= '0;
            end
        end else if (new_best) begin
            best[result.chart_id] <= result.score;
        end
    end

    assign best_score = best[rd_id];

endmodule

// File: page_menu.sv
`timescale 1ns/1ps

module page_menu (
    input  logic                       clk,
    input  logic                       sys_rst,
    input  logic                       start,
    input  logic                       active,
    input  rhythm_game_pkg::user_in_t  user_in,
    input  rhythm_game_pkg::score_t    best_score,
    output rhythm_game_pkg::page_t     next_page,
    output rhythm_game_pkg::chart_id_t chart_id,
    output logic                       rec_mode,
    output rhythm_game_pkg::chart_id_t rd_id,
    output rhythm_game_pkg::score_t    best_shown
);

    // Selection survives a run, so only reset clears it
    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            chart_id <= '0;
            rec_mode <= 1'b0;
        end else if (active) begin
            // Two-bit id wraps on its own
            if (user_in.up) begin
                chart_id <= chart_id + 1'b1;
            end else if (user_in.down) begin
                chart_id <= chart_id - 1'b1;
            end
            if (user_in.rec) begin
                rec_mode <= !rec_mode;
            end
        end
    end

    assign rd_id = chart_id;

    // Best score of the selection, reloaded on entry and tracked while shown
    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            best_shown <= '0;
        end else if (start || active) begin
            best_shown <= best_score;
        end
    end

    assign next_page = (active && user_in.enter) ? rhythm_game_pkg::PAGE_PLAY
                                                 : rhythm_game_pkg::PAGE_MENU;

endmodule

// File: page_play.sv
`timescale 1ns/1ps

module page_play (
    input  logic                          clk,
    input  logic                          sys_rst,
    input  logic                          start,
    input  logic                          active,
    input  rhythm_game_pkg::user_in_t     user_in,
    input  rhythm_game_pkg::chart_id_t    chart_id,
    input  logic                          rec_mode,
    input  rhythm_game_pkg::note_mask_t   chart_rd_data,
    input  logic                          result_ready,
    output rhythm_game_pkg::chart_addr_t  chart_rd_addr,
    output logic                          chart_wr_en,
    output rhythm_game_pkg::chart_addr_t  chart_wr_addr,
    output rhythm_game_pkg::note_mask_t   chart_wr_data,
    output rhythm_game_pkg::play_result_t result,
    output logic                          result_valid,
    output rhythm_game_pkg::page_t        next_page,
    output rhythm_game_pkg::step_idx_t    step_idx,
    output rhythm_game_pkg::score_t       score
);

    typedef enum logic {
        ST_RUN,
        ST_OFFER
    } play_state_t;

    play_state_t                     state;
    logic [$clog2(rhythm_game_pkg::STEP_CYCLES)-1:0] cyc;
    rhythm_game_pkg::note_mask_t     acc;
    rhythm_game_pkg::note_mask_t     slot_mask;
    rhythm_game_pkg::score_t         misses;
    logic                            running;
    logic                            abort;
    logic                            slot_end;
    logic                            last_slot;
    logic                            accept;

    // Back only counts while slots are running, an offered result must be taken
    assign abort     = active && (state == ST_RUN) && user_in.back;
    assign running   = active && (state == ST_RUN) && !user_in.back;
    assign slot_end  = running && (cyc == rhythm_game_pkg::STEP_CYCLES - 1);
    assign last_slot = step_idx == rhythm_game_pkg::CHART_LEN - 1;
    assign accept    = result_valid && result_ready;

    // Presses of the current cycle still belong to this slot
    assign slot_mask = acc | user_in.note_press;

    // Address is stable for the whole slot, so read data is ready by its end
    assign chart_rd_addr = {chart_id, step_idx};
    assign chart_wr_addr = chart_rd_addr;
    assign chart_wr_en   = slot_end && rec_mode;
    assign chart_wr_data = slot_mask;

    assign result_valid = state == ST_OFFER;
    assign result       = '{chart_id: chart_id, rec_mode: rec_mode, score: score,
                            misses: misses};

    assign next_page = (abort || accept) ? rhythm_game_pkg::PAGE_MENU
                                         : rhythm_game_pkg::PAGE_PLAY;

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            state    <= ST_RUN;
            cyc      <= '0;
            step_idx <= '0;
            acc      <= '0;
            score    <= '0;
            misses   <= '0;
        end else if (start) begin
            state    <= ST_RUN;
            cyc      <= '0;
            step_idx <= '0;
            acc      <= '0;
            score    <= '0;
            misses   <= '0;
        end else if (accept) begin
            state <= ST_RUN;
        end else if (slot_end) begin
            cyc <= '0;
            acc <= '0;
            if (rec_mode) begin
                // Record runs count the notes written
                score <= score + rhythm_game_pkg::score_t'($countones(slot_mask));
            end else begin
                score  <= score + rhythm_game_pkg::score_t'(
                              $countones(slot_mask & chart_rd_data));
                misses <= misses + rhythm_game_pkg::score_t'(
                              $countones(slot_mask & ~chart_rd_data));
            end
            if (last_slot) begin
                state <= ST_OFFER;
            end else begin
                step_idx <= step_idx + 1'b1;
            end
        end else if (running) begin
            cyc <= cyc + 1'b1;
            acc <= slot_mask;
        end
    end

endmodule

// File: rhythm_game_top.sv
`timescale 1ns/1ps

module rhythm_game_top (
    input  logic                          clk,
    input  logic                          sys_rst,
    input  rhythm_game_pkg::note_mask_t   note_keys,
    input  logic                          btn_up,
    input  logic                          btn_down,
    input  logic                          btn_enter,
    input  logic                          btn_back,
    input  logic                          btn_rec,
    input  logic                          result_ready,
    output rhythm_game_pkg::game_status_t status,
    output rhythm_game_pkg::play_result_t result,
    output logic                          result_valid
);

    rhythm_game_pkg::page_t       cur_page;
    rhythm_game_pkg::page_t       req_page;
    rhythm_game_pkg::page_t       menu_next;
    rhythm_game_pkg::page_t       play_next;
    logic                         menu_start;
    logic                         play_start;
    logic                         menu_active;
    logic                         play_active;
    rhythm_game_pkg::user_in_t    user_in;
    rhythm_game_pkg::chart_id_t   chart_id;
    rhythm_game_pkg::chart_id_t   rd_id;
    logic                         rec_mode;
    rhythm_game_pkg::score_t      best_score;
    rhythm_game_pkg::score_t      best_shown;
    rhythm_game_pkg::chart_addr_t chart_rd_addr;
    rhythm_game_pkg::chart_addr_t chart_wr_addr;
    logic                         chart_wr_en;
    rhythm_game_pkg::note_mask_t  chart_wr_data;
    rhythm_game_pkg::note_mask_t  chart_rd_data;
    rhythm_game_pkg::step_idx_t   step_idx;
    rhythm_game_pkg::score_t      score;

    key_input_unit i_keys (
        .clk(clk), .sys_rst(sys_rst),
        .note_keys(note_keys),
        .btn_up(btn_up), .btn_down(btn_down), .btn_enter(btn_enter),
        .btn_back(btn_back), .btn_rec(btn_rec),
        .user_in(user_in)
    );

    chart_store i_charts (
        .clk(clk), .sys_rst(sys_rst),
        .rd_addr(chart_rd_addr), .wr_en(chart_wr_en),
        .wr_addr(chart_wr_addr), .wr_data(chart_wr_data),
        .rd_data(chart_rd_data)
    );

    record_store i_records (
        .clk(clk), .sys_rst(sys_rst),
        .result(result), .result_valid(result_valid), .result_ready(result_ready),
        .rd_id(rd_id), .best_score(best_score)
    );

    page_menu i_menu (
        .clk(clk), .sys_rst(sys_rst),
        .start(menu_start), .active(menu_active), .user_in(user_in),
        .best_score(best_score), .next_page(menu_next),
        .chart_id(chart_id), .rec_mode(rec_mode), .rd_id(rd_id),
        .best_shown(best_shown)
    );

    page_play i_play (
        .clk(clk), .sys_rst(sys_rst),
        .start(play_start), .active(play_active), .user_in(user_in),
        .chart_id(chart_id), .rec_mode(rec_mode),
        .chart_rd_data(chart_rd_data), .result_ready(result_ready),
        .chart_rd_addr(chart_rd_addr), .chart_wr_en(chart_wr_en),
        .chart_wr_addr(chart_wr_addr), .chart_wr_data(chart_wr_data),
        .result(result), .result_valid(result_valid),
        .next_page(play_next), .step_idx(step_idx), .score(score)
    );

    // Only the current page decides where to go next
    always_comb begin
        case (cur_page)
            rhythm_game_pkg::PAGE_PLAY: req_page = play_next;
            default:                    req_page = menu_next;
        endcase
    end

    assign menu_active = cur_page == rhythm_game_pkg::PAGE_MENU;
    assign play_active = cur_page == rhythm_game_pkg::PAGE_PLAY;

    // Start goes to the entered page in the cycle before it becomes current
    assign menu_start = (req_page != cur_page) && (req_page == rhythm_game_pkg::PAGE_MENU);
    assign play_start = (req_page != cur_page) && (req_page == rhythm_game_pkg::PAGE_PLAY);

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            cur_page <= rhythm_game_pkg::PAGE_MENU;
        end else begin
            cur_page <= req_page;
        end
    end

    assign status = '{page: cur_page, chart_id: chart_id, rec_mode: rec_mode,
                      step_idx: step_idx, score: score, best_score: best_shown};

endmodule

// File: rhythm_game_sva.sv
`timescale 1ns/1ps

module rhythm_game_sva (
    input logic                          clk,
    input logic                          sys_rst,
    input logic                          result_valid,
    input logic                          result_ready,
    input rhythm_game_pkg::play_result_t result,
    input rhythm_game_pkg::game_status_t status
);

    localparam int MAX_SCORE = rhythm_game_pkg::N_NOTES * rhythm_game_pkg::CHART_LEN;

    // A stalled offer keeps valid high and its payload unchanged
    offer_held: assert property (@(posedge clk) disable iff (sys_rst)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else $error("result_valid dropped or result changed before ready");

    valid_in_play: assert property (@(posedge clk) disable iff (sys_rst)
        status.page != rhythm_game_pkg::PAGE_PLAY |-> !result_valid)
        else $error("result_valid high outside the play page");

    score_range: assert property (@(posedge clk) disable iff (sys_rst)
        status.score <= rhythm_game_pkg::score_t'(MAX_SCORE))
        else $error("score above the note count of a chart");

endmodule

bind rhythm_game_top rhythm_game_sva i_sva (
    .clk(clk),
    .sys_rst(sys_rst),
    .result_valid(result_valid),
    .result_ready(result_ready),
    .result(result),
    .status(status)
);

// File: tb_rhythm_game.sv
`timescale 1ns/1ps

module tb_rhythm_game;

    localparam int CLK_PERIOD = 40;
    // Each run, with its menu steps, fits in 20 slots
    localparam int RUN_BUDGET = 12;
    localparam int BTN_UP     = 0;
    localparam int BTN_DOWN   = 1;
    localparam int BTN_ENTER  = 2;
    localparam int BTN_BACK   = 3;
    localparam int BTN_REC    = 4;
    localparam int N_CHARTS   = rhythm_game_pkg::N_CHARTS;
    localparam int CHART_LEN  = rhythm_game_pkg::CHART_LEN;
    localparam int SLOT_LIMIT = 2 * rhythm_game_pkg::STEP_CYCLES;

    logic                          clk;
    logic                          sys_rst;
    rhythm_game_pkg::note_mask_t   note_keys;
    logic                          btn_up;
    logic                          btn_down;
    logic                          btn_enter;
    logic                          btn_back;
    logic                          btn_rec;
    logic                          result_ready;
    rhythm_game_pkg::game_status_t status;
    rhythm_game_pkg::play_result_t result;
    logic                          result_valid;

    // Reference model of selection, charts and best scores
    int                            m_chart;
    logic                          m_rec;
    rhythm_game_pkg::note_mask_t   m_charts [N_CHARTS][CHART_LEN];
    int                            m_best [N_CHARTS];
    rhythm_game_pkg::note_mask_t   run_masks [CHART_LEN];
    int                            dut_score;
    int                            dut_misses;
    int                            n_checks;
    int                            n_errors;
    logic                          valid_seen;

    rhythm_game_top i_dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (result_valid) begin
            valid_seen = 1'b1;
        end
    end

    initial begin
        #(RUN_BUDGET * 20 * rhythm_game_pkg::STEP_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        n_errors++;
        $display("ERROR: %s", what);
    endtask

    task automatic report_test(input string name, input int err_start);
        if (n_errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, n_errors - err_start);
        end
    endtask

    function automatic int count_bits(input rhythm_game_pkg::note_mask_t m);
        int c;
        c = 0;
        for (int i = 0; i < rhythm_game_pkg::N_NOTES; i++) begin
            c += int'(m[i]);
        end
        return c;
    endfunction

    task automatic check_menu();
        check("status.page", status.page, rhythm_game_pkg::PAGE_MENU);
        check("status.chart_id", status.chart_id, m_chart);
        check("status.rec_mode", status.rec_mode, m_rec);
        check("status.best_score", status.best_score, m_best[m_chart]);
        check("result_valid", result_valid, 0);
    endtask

    task automatic pulse_button(input int which);
        @(posedge clk);
        btn_up    <= (which == BTN_UP);
        btn_down  <= (which == BTN_DOWN);
        btn_enter <= (which == BTN_ENTER);
        btn_back  <= (which == BTN_BACK);
        btn_rec   <= (which == BTN_REC);
        @(posedge clk);
        {btn_up, btn_down, btn_enter, btn_back, btn_rec} <= '0;
        // Three cycles through the synchronizer, then one to act on it
        repeat (5) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic menu_press(input int which);
        pulse_button(which);
        if (which == BTN_UP) begin
            m_chart = (m_chart + 1) % N_CHARTS;
        end else if (which == BTN_DOWN) begin
            m_chart = (m_chart + N_CHARTS - 1) % N_CHARTS;
        end else if (which == BTN_REC) begin
            m_rec = !m_rec;
        end
        check_menu();
    endtask

    task automatic select_chart(input int target, input logic rec);
        while (m_chart != target) begin
            menu_press(BTN_UP);
        end
        if (m_rec != rec) begin
            menu_press(BTN_REC);
        end
    endtask

    task automatic drive_notes(input rhythm_game_pkg::note_mask_t mask);
        @(posedge clk);
        note_keys <= mask;
        @(posedge clk);
        note_keys <= '0;
    endtask

    task automatic fill_masks();
        for (int k = 0; k < CHART_LEN; k++) begin
            run_masks[k] = rhythm_game_pkg::note_mask_t'($urandom);
        end
    endtask

    task automatic wait_step(input int k, output bit ok);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(status.page == rhythm_game_pkg::PAGE_PLAY && int'(status.step_idx) == k)
                   && n < SLOT_LIMIT);
        ok = (n < SLOT_LIMIT);
        if (!ok) begin
            report_error($sformatf("play page did not reach slot %0d", k));
        end
    endtask

    // Each slot gets its mask in two disjoint halves, a few cycles apart
    task automatic play_slots(input int n_slots, output bit ok);
        rhythm_game_pkg::note_mask_t split;
        ok = 1'b1;
        for (int k = 0; k < n_slots && ok; k++) begin
            wait_step(k, ok);
            split = rhythm_game_pkg::note_mask_t'($urandom);
            drive_notes(run_masks[k] & split);
            drive_notes(run_masks[k] & ~split);
        end
    endtask

    task automatic take_result(input int exp_score, input int exp_misses);
        logic rdy;
        int   stalls;
        bit   done;
        stalls = 0;
        done   = 1'b0;
        while (!done) begin
            rdy = (($urandom % 3) == 0) || (stalls >= 5);
            @(posedge clk);
            result_ready <= rdy;
            @(negedge clk);
            check("result_valid", result_valid, 1);
            check("status.page", status.page, rhythm_game_pkg::PAGE_PLAY);
            check("result.chart_id", result.chart_id, m_chart);
            check("result.rec_mode", result.rec_mode, m_rec);
            check("result.score", result.score, exp_score);
            check("result.misses", result.misses, exp_misses);
            check("status.score", status.score, exp_score);
            dut_score  = int'(result.score);
            dut_misses = int'(result.misses);
            done = rdy;
            stalls++;
        end
        // Transfer edge
        @(posedge clk);
        result_ready <= 1'b0;
        @(negedge clk);
        check("result_valid", result_valid, 0);
        check("status.page", status.page, rhythm_game_pkg::PAGE_MENU);
    endtask

    task automatic run_chart();
        int                          exp_score;
        int                          exp_misses;
        int                          n;
        rhythm_game_pkg::note_mask_t slot;
        bit                          ok;
        exp_score  = 0;
        exp_misses = 0;
        for (int k = 0; k < CHART_LEN; k++) begin
            slot = m_charts[m_chart][k];
            if (m_rec) begin
                exp_score += count_bits(run_masks[k]);
            end else begin
                exp_score  += count_bits(run_masks[k] & slot);
                exp_misses += count_bits(run_masks[k] & ~slot);
            end
        end
        pulse_button(BTN_ENTER);
        play_slots(CHART_LEN, ok);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!result_valid && n < SLOT_LIMIT);
        if (!result_valid) begin
            report_error("result_valid did not rise after the last slot");
        end else begin
            take_result(exp_score, exp_misses);
        end
        if (m_rec) begin
            for (int k = 0; k < CHART_LEN; k++) begin
                m_charts[m_chart][k] = run_masks[k];
            end
        end else if (exp_score > m_best[m_chart]) begin
            m_best[m_chart] = exp_score;
        end
        repeat (4) @(negedge clk);
        check_menu();
    endtask

    initial begin
        int err_start;
        int total_bits;
        int best_before;
        bit ok;
        sys_rst      = 1'b1;
        note_keys    = '0;
        btn_up       = 1'b0;
        btn_down     = 1'b0;
        btn_enter    = 1'b0;
        btn_back     = 1'b0;
        btn_rec      = 1'b0;
        result_ready = 1'b0;
        n_checks     = 0;
        n_errors     = 0;
        m_chart      = 0;
        m_rec        = 1'b0;
        valid_seen   = 1'b0;
        for (int c = 0; c < N_CHARTS; c++) begin
            m_best[c] = 0;
            for (int k = 0; k < CHART_LEN; k++) begin
                m_charts[c][k] = '0;
            end
        end
        void'($urandom(32'hff91_b346));
        repeat (3) @(posedge clk);
        sys_rst <= 1'b0;
        @(negedge clk);

        err_start = n_errors;
        check_menu();
        report_test("reset state", err_start);

        err_start = n_errors;
        for (int i = 0; i < 16; i++) begin
            case ($urandom % 3)
                0:       menu_press(BTN_UP);
                1:       menu_press(BTN_DOWN);
                default: menu_press(BTN_REC);
            endcase
        end
        // Note keys mean nothing on the menu page
        for (int i = 0; i < 4; i++) begin
            drive_notes(rhythm_game_pkg::note_mask_t'($urandom) | 7'h01);
            repeat (5) @(negedge clk);
            check_menu();
        end
        report_test("menu navigation", err_start);

        err_start = n_errors;
        select_chart(2, 1'b1);
        fill_masks();
        total_bits = 0;
        for (int k = 0; k < CHART_LEN; k++) begin
            total_bits += count_bits(run_masks[k]);
        end
        run_chart();
        check("record score", dut_score, total_bits);
        select_chart(2, 1'b0);
        run_chart();
        check("replay score", dut_score, total_bits);
        check("replay misses", dut_misses, 0);
        report_test("record and replay", err_start);

        err_start = n_errors;
        select_chart(1, 1'b1);
        fill_masks();
        run_chart();
        select_chart(1, 1'b0);
        for (int i = 0; i < 3; i++) begin
            fill_masks();
            run_chart();
        end
        report_test("play runs with back-pressure", err_start);

        err_start = n_errors;
        best_before = m_best[1];
        select_chart(1, 1'b1);
        fill_masks();
        run_chart();
        check("best_score after record", status.best_score, best_before);
        select_chart(1, 1'b0);
        fill_masks();
        run_chart();
        report_test("best score", err_start);

        err_start = n_errors;
        best_before = m_best[m_chart];
        fill_masks();
        valid_seen = 1'b0;
        pulse_button(BTN_ENTER);
        play_slots(3, ok);
        pulse_button(BTN_BACK);
        check("valid_seen", valid_seen, 0);
        check("best_score after abort", status.best_score, best_before);
        check_menu();
        report_test("abort", err_start);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: rhythm_game.f
rhythm_game_pkg.sv
key_input_unit.sv
chart_store.sv
record_store.sv
page_menu.sv
page_play.sv
rhythm_game_top.sv
rhythm_game_sva.sv
tb_rhythm_game.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the rhythm game testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rhythm_game \
    -f rhythm_game.f -o sim_rhythm_game \
    && { ./obj_dir/sim_rhythm_game > sim.log 2>&1 || echo "sim failed" >> sim.log; } \
    || echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
